/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module decodeTb -f verilog.f --Mdir obj_dir -o decodeTb
	./obj_dir/decodeTb | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/decodeTb.sv */
`timescale 1ns/1ps

module decodeTb import decodePkg::*; ();

    localparam int clkPeriod = 8;
    localparam int testCycles = 5 + 13 + 6 * 50 + 1 + 10 + 32 + 12 + 6;
    localparam int marginCycles = 100;

    // full 7-bit major opcodes
    localparam logic [6:0] opcLoad = 7'b0000011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcAuipc = 7'b0010111;
    localparam logic [6:0] opcOpImmW = 7'b0011011;
    localparam logic [6:0] opcStore = 7'b0100011;
    localparam logic [6:0] opcOp = 7'b0110011;
    localparam logic [6:0] opcLui = 7'b0110111;
    localparam logic [6:0] opcOpW = 7'b0111011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJalr = 7'b1100111;
    localparam logic [6:0] opcJal = 7'b1101111;
    localparam logic [6:0] opcSystem = 7'b1110011;

    logic clk, rstN, stall, jmp, validIn, instrError, csrError;
    logic [31:0] instr;
    logic [63:0] pcIn;
    logic wbValid;
    logic [4:0] wbRd;
    logic issueValid, rsBlock;
    logic [63:0] pc;
    logic [4:0] rd, rs1, rs2;
    logic [31:0] imm;
    aluOpT aluOp;
    logic aluWord, mulDiv, aluASrcPc;
    srcBT srcB;
    branchT branch;
    logic memRd, memWr;
    logic [2:0] memOp;
    logic regWr, isCsr, isEcall, isMret, isEbreak, illegal;

    int seed;
    logic [63:0] pcNext;       // pc handed to the next accepted instruction

    decodeTop i_decodeTop (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkEq(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %0h, actual %0h", what, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // outputs show ins after one accept edge
    task automatic accept(input logic [31:0] ins, input logic [63:0] pcVal);
        validIn = 1'b1;
        instr = ins;
        pcIn = pcVal;
        nextCycle();
        validIn = 1'b0;
    endtask

    task automatic flushStage();
        validIn = 1'b0;
        instr = 32'h0000_0013;  // addi x0, x0, 0
        nextCycle();
    endtask

    task automatic releaseAll();
        flushStage();
        for (int r = 1; r < regCount; r++) begin
            wbValid = 1'b1;
            wbRd = 5'(r);
            nextCycle();
        end
        wbValid = 1'b0;
    endtask

    function automatic logic [6:0] fmtOpcode(input immFmtT fmt);
        case (fmt)
            fmtI: return opcOpImm;
            fmtS: return opcStore;
            fmtB: return opcBranch;
            fmtU: return opcLui;
            fmtJ: return opcJal;
            default: return opcOp;
        endcase
    endfunction

    // standard RISC-V immediate layouts
    function automatic logic [31:0] refImm(input immFmtT fmt, input logic [31:0] ins);
        logic [11:0] i12;
        logic [11:0] s12;
        logic [12:0] b13;
        logic [20:0] j21;
        i12 = ins[31:20];
        s12 = {ins[31:25], ins[11:7]};
        b13 = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        j21 = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        case (fmt)
            fmtI: return {{20{i12[11]}}, i12};
            fmtS: return {{20{s12[11]}}, s12};
            fmtB: return {{19{b13[12]}}, b13};
            fmtU: return {ins[31:12], 12'h000};
            fmtJ: return {{11{j21[20]}}, j21};
            default: return 32'h0;
        endcase
    endfunction

    task automatic resetTest();
        rstN = 1'b0;
        for (int n = 0; n < 4; n++) begin
            nextCycle();
            checkEq("reset issueValid", 0, 64'(issueValid));
            checkEq("reset rsBlock", 0, 64'(rsBlock));
        end
        rstN = 1'b1;
        nextCycle();
        checkEq("post-reset issueValid", 0, 64'(issueValid));
        checkEq("post-reset rsBlock", 0, 64'(rsBlock));
    endtask

    // expFlags holds memRd, memWr, regWr, isCsr, aluWord, mulDiv, aluASrcPc from the top
    task automatic checkDecode(input string name, input logic [31:0] ins, input aluOpT expAlu,
                               input srcBT expSrcB, input branchT expBranch,
                               input logic [6:0] expFlags);
        accept(ins, pcNext);
        checkEq({name, " pc"}, pcNext, pc);
        checkEq({name, " issueValid"}, 1, 64'(issueValid));
        checkEq({name, " aluOp"}, 64'(expAlu), 64'(aluOp));
        checkEq({name, " srcB"}, 64'(expSrcB), 64'(srcB));
        checkEq({name, " branch"}, 64'(expBranch), 64'(branch));
        checkEq({name, " memRd"}, 64'(expFlags[6]), 64'(memRd));
        checkEq({name, " memWr"}, 64'(expFlags[5]), 64'(memWr));
        checkEq({name, " regWr"}, 64'(expFlags[4]), 64'(regWr));
        checkEq({name, " isCsr"}, 64'(expFlags[3]), 64'(isCsr));
        checkEq({name, " aluWord"}, 64'(expFlags[2]), 64'(aluWord));
        checkEq({name, " mulDiv"}, 64'(expFlags[1]), 64'(mulDiv));
        checkEq({name, " aluASrcPc"}, 64'(expFlags[0]), 64'(aluASrcPc));
        checkEq({name, " memOp"}, 64'(ins[14:12]), 64'(memOp));   // funct3 passes through
        checkEq({name, " illegal"}, 0, 64'(illegal));
        pcNext = pcNext + 4;
    endtask

    task automatic decodeTableTest();
        checkDecode("lui", {20'h12345, 5'd1, opcLui}, aluPass, srcImm, brNone, 7'b0010000);
        checkDecode("auipc", {20'h00010, 5'd2, opcAuipc}, aluAdd, srcImm, brNone, 7'b0010001);
        checkDecode("jal", {20'h00100, 5'd1, opcJal}, aluAdd, srcFour, brJal, 7'b0010001);
        checkDecode("jalr", {12'h010, 5'd0, 3'b000, 5'd1, opcJalr},
                    aluAdd, srcFour, brJalr, 7'b0010001);
        checkDecode("beq", {7'd0, 5'd0, 5'd0, 3'b000, 5'd8, opcBranch},
                    aluSlt, srcRs2, brEq, 7'b0000000);
        checkDecode("bltu", {7'd0, 5'd0, 5'd0, 3'b110, 5'd8, opcBranch},
                    aluSltu, srcRs2, brLt, 7'b0000000);    // unsigned compare
        checkDecode("ld", {12'h008, 5'd0, 3'b011, 5'd2, opcLoad},
                    aluAdd, srcImm, brNone, 7'b1010000);
        checkDecode("sd", {7'd0, 5'd0, 5'd0, 3'b011, 5'd16, opcStore},
                    aluAdd, srcImm, brNone, 7'b0100000);
        checkDecode("addi", {12'h005, 5'd0, 3'b000, 5'd3, opcOpImm},
                    aluAdd, srcImm, brNone, 7'b0010000);
        checkDecode("sraiw", {7'b0100000, 5'd3, 5'd0, 3'b101, 5'd4, opcOpImmW},
                    aluSra, srcImm, brNone, 7'b0010100);
        checkDecode("sub", {7'b0100000, 5'd0, 5'd0, 3'b000, 5'd6, opcOp},
                    aluSub, srcRs2, brNone, 7'b0010000);
        checkDecode("mulw", {7'b0000001, 5'd0, 5'd0, 3'b000, 5'd7, opcOpW},
                    aluAdd, srcRs2, brNone, 7'b0010110);
        checkDecode("csrrw", {12'h300, 5'd0, 3'b001, 5'd8, opcSystem},
                    aluPass, srcCsr, brNone, 7'b0011000);
    endtask

    task automatic immTest();
        immFmtT fmts [6];
        immFmtT fmt;
        logic [31:0] r;
        logic [31:0] ins;
        fmts = '{fmtI, fmtS, fmtB, fmtU, fmtJ, fmtR};
        jmp = 1'b1;                     // nothing issues so the scoreboard stays untouched
        for (int f = 0; f < 6; f++) begin
            fmt = fmts[f];
            for (int n = 0; n < 50; n++) begin
                r = $random(seed);
                ins = {r[31:7], fmtOpcode(fmt)};
                validIn = 1'b1;
                instr = ins;
                pcIn = pcNext;
                nextCycle();
                checkEq($sformatf("imm %s #%0d", fmt.name(), n),
                        64'(refImm(fmt, ins)), 64'(imm));
            end
        end
        flushStage();
        jmp = 1'b0;
    endtask

    // expFlags holds illegal, isEcall, isEbreak, isMret from the top
    task automatic checkFlags(input string name, input logic [31:0] ins,
                              input logic [3:0] expFlags);
        accept(ins, pcNext);
        checkEq({name, " illegal"}, 64'(expFlags[3]), 64'(illegal));
        checkEq({name, " isEcall"}, 64'(expFlags[2]), 64'(isEcall));
        checkEq({name, " isEbreak"}, 64'(expFlags[1]), 64'(isEbreak));
        checkEq({name, " isMret"}, 64'(expFlags[0]), 64'(isMret));
        pcNext = pcNext + 4;
    endtask

    task automatic illegalTest();
        checkFlags("low bits 2", {12'h001, 5'd0, 3'b000, 5'd9, 7'b0010010}, 4'b1000);
        checkFlags("load funct3 7", {12'h000, 5'd0, 3'b111, 5'd9, opcLoad}, 4'b1000);
        checkFlags("branch funct3 2", {7'd0, 5'd0, 5'd0, 3'b010, 5'd4, opcBranch}, 4'b1000);
        checkFlags("system unknown", 32'h0020_0073, 4'b1000);
        csrError = 1'b1;
        checkFlags("csrrs csrError", {12'h300, 5'd0, 3'b010, 5'd9, opcSystem}, 4'b1000);
        csrError = 1'b0;
        instrError = 1'b1;              // fetch fault rides along with the instruction
        checkFlags("instrError", {12'h001, 5'd0, 3'b000, 5'd9, opcOpImm}, 4'b1000);
        instrError = 1'b0;
        checkFlags("ecall", 32'h0000_0073, 4'b0100);
        checkFlags("ebreak", 32'h0010_0073, 4'b0010);
        checkFlags("mret", 32'h3020_0073, 4'b0001);
    endtask

    task automatic rawTest();
        releaseAll();
        accept({12'h001, 5'd0, 3'b000, 5'd5, opcOpImm}, 64'h2000);    // addi x5, x0, 1
        checkEq("raw addi issueValid", 1, 64'(issueValid));
        accept({7'd0, 5'd1, 5'd5, 3'b000, 5'd6, opcOp}, 64'h2004);    // add x6, x5, x1
        checkEq("raw add rs1", 5, 64'(rs1));
        checkEq("raw add rs2", 1, 64'(rs2));
        checkEq("raw add rsBlock", 1, 64'(rsBlock));
        checkEq("raw add issueValid", 0, 64'(issueValid));
        validIn = 1'b1;
        instr = {20'h00028, 5'd9, opcLui};      // imm bits [19:15] read as x5
        pcIn = 64'h2008;
        for (int n = 0; n < 3; n++) begin
            nextCycle();
            checkEq("raw hold pc", 64'h2004, pc);
            checkEq("raw hold rsBlock", 1, 64'(rsBlock));
        end
        wbValid = 1'b1;
        wbRd = 5'd5;
        nextCycle();
        wbValid = 1'b0;
        checkEq("raw issueValid after wb", 1, 64'(issueValid));
        checkEq("raw pc after wb", 64'h2004, pc);
        accept({12'h001, 5'd0, 3'b000, 5'd5, opcOpImm}, 64'h200c);    // x5 pending again
        accept({20'h00028, 5'd9, opcLui}, 64'h2010);
        checkEq("raw lui rs1 field", 5, 64'(rs1));
        checkEq("raw lui rsBlock", 0, 64'(rsBlock));
        checkEq("raw lui issueValid", 1, 64'(issueValid));
    endtask

    task automatic stallJmpTest();
        accept({12'h007, 5'd0, 3'b000, 5'd10, opcOpImm}, 64'h3000);   // addi x10, x0, 7
        stall = 1'b1;
        validIn = 1'b1;
        instr = {7'd0, 5'd0, 5'd10, 3'b000, 5'd12, opcOp};    // add x12, x10, x0
        pcIn = 64'h3004;
        for (int n = 0; n < 3; n++) begin
            nextCycle();
            checkEq("stall pc", 64'h3000, pc);
            checkEq("stall imm", 7, 64'(imm));
            checkEq("stall rd", 10, 64'(rd));
        end
        stall = 1'b0;
        nextCycle();
        checkEq("stall release pc", 64'h3004, pc);
        checkEq("add on pending x10 rsBlock", 1, 64'(rsBlock));
        jmp = 1'b1;
        instr = {12'h00d, 5'd0, 3'b000, 5'd13, opcOpImm};
        pcIn = 64'h3008;
        #1;
        checkEq("jmp issueValid", 0, 64'(issueValid));
        checkEq("jmp rsBlock", 0, 64'(rsBlock));
        nextCycle();
        jmp = 1'b0;
        validIn = 1'b0;
        #1;
        checkEq("after jmp pc", 64'h3008, pc);
        checkEq("after jmp issueValid", 1, 64'(issueValid));
    endtask

    initial begin
        seed = 11650;
        rstN = 1'b0;
        stall = 1'b0;
        jmp = 1'b0;
        validIn = 1'b0;
        instrError = 1'b0;
        csrError = 1'b0;
        instr = 32'h0000_0013;
        pcIn = 64'h0;
        wbValid = 1'b0;
        wbRd = 5'd0;
        pcNext = 64'h1000;
        resetTest();
        decodeTableTest();
        immTest();
        illegalTest();
        rawTest();
        stallJmpTest();
        $display("all tests passed");
        $finish;
    end

    initial begin
        #((testCycles + marginCycles) * clkPeriod);
        $display("timeout after %0d cycles, the stimulus never finished",
                 testCycles + marginCycles);
        $display("tests failed");
        $fatal(1);
    end

endmodule

/* design/decodeCtrlIf.sv */
`timescale 1ns/1ps

interface decodeCtrlIf import decodePkg::*; ();

    immFmtT      immFmt;
    aluOpT       aluOp;
    logic        aluWord;     // 32-bit op, result sign-extended
    logic        mulDiv;
    logic        aluASrcPc;
    srcBT        srcB;
    branchT      branch;
    logic        memRd;
    logic        memWr;
    logic [2:0]  memOp;       // load/store width and sign
    logic        regWr;
    logic        isCsr;
    logic        decErr;

    modport producer (
        output immFmt, aluOp, aluWord, mulDiv, aluASrcPc, srcB, branch,
        output memRd, memWr, memOp, regWr, isCsr, decErr
    );

    modport consumer (
        input immFmt, aluOp, aluWord, mulDiv, aluASrcPc, srcB, branch,
        input memRd, memWr, memOp, regWr, isCsr, decErr
    );

endinterface

/* design/decodePkg.sv */
package decodePkg;

    localparam int xlen = 64;         // pc width
    localparam int regCount = 32;     // architectural integer registers

    // exact system encodings
    localparam logic [31:0] instrEcall = 32'h0000_0073;
    localparam logic [31:0] instrEbreak = 32'h0010_0073;
    localparam logic [31:0] instrMret = 32'h3020_0073;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        opLoad   = 5'b00000,
        opOpImm  = 5'b00100,
        opAuipc  = 5'b00101,
        opOpImmW = 5'b00110,
        opStore  = 5'b01000,
        opOp     = 5'b01100,
        opLui    = 5'b01101,
        opOpW    = 5'b01110,
        opBranch = 5'b11000,
        opJalr   = 5'b11001,
        opJal    = 5'b11011,
        opSystem = 5'b11100
    } opcodeT;

    typedef enum logic [2:0] {
        fmtI,
        fmtS,
        fmtB,
        fmtU,
        fmtJ,
        fmtR                          // no immediate
    } immFmtT;

    // funct3 with the sub/sra bit on top
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101,
        aluPass = 4'b1111             // b operand straight through
    } aluOpT;

    typedef enum logic [2:0] {
        brNone,
        brJal,
        brJalr,
        brEq,
        brNe,
        brLt,
        brGe
    } branchT;

    typedef enum logic [1:0] {
        srcRs2,
        srcFour,
        srcImm,
        srcCsr
    } srcBT;

endpackage

/* design/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  logic              jmp,
    input  logic              validIn,
    input  logic              instrError,
    input  logic              csrError,
    input  logic [31:0]       instrIn,
    input  logic [xlen-1:0]   pcIn,
    input  logic              rs1Ready,
    input  logic              rs2Ready,
    decodeCtrlIf.consumer     ctrl,
    output logic [31:0]       instr,
    output logic [xlen-1:0]   pc,
    output logic              issueValid,
    output logic              rsBlock,
    output logic              isEcall,
    output logic              isMret,
    output logic              isEbreak,
    output logic              illegal
);

    logic        validReg;
    logic        instrErrReg;
    logic        load;
    logic        srcPending;
    logic        sysMatch;
    logic [2:0]  funct3;

    assign load = !stall && !rsBlock;     // hold on stall or hazard

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validReg <= 1'b0;
            instrErrReg <= 1'b0;
        end else if (load) begin
            validReg <= validIn;
            instrErrReg <= instrError;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            instr <= instrIn;
            pc <= pcIn;
        end
    end

    // sources read by each format
    always_comb begin
        case (ctrl.immFmt)
            fmtI: srcPending = !rs1Ready;
            fmtS, fmtB, fmtR: srcPending = !rs1Ready || !rs2Ready;
            default: srcPending = 1'b0;   // lui, auipc, jal
        endcase
    end

    assign rsBlock = validReg && !jmp && srcPending;
    assign issueValid = validReg && !rsBlock && !jmp;   // jmp masks only

    assign isEcall = (instr == instrEcall);
    assign isEbreak = (instr == instrEbreak);
    assign isMret = (instr == instrMret);
    assign sysMatch = isEcall || isEbreak || isMret;

    assign funct3 = instr[14:12];

    // funct3 zero under SYSTEM is only legal for the three exact encodings
    assign illegal = ctrl.decErr || instrErrReg ||
                     (ctrl.isCsr && funct3 == 3'b000 && !sysMatch) ||
                     (ctrl.isCsr && funct3 != 3'b000 && csrError);

endmodule

/* design/decodeTop.sv */
`timescale 1ns/1ps

module decodeTop import decodePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  logic              jmp,
    input  logic              validIn,
    input  logic              instrError,
    input  logic              csrError,
    input  logic [31:0]       instr,
    input  logic [xlen-1:0]   pcIn,
    input  logic              wbValid,
    input  logic [4:0]        wbRd,
    output logic              issueValid,
    output logic              rsBlock,
    output logic [xlen-1:0]   pc,
    output logic [4:0]        rd,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [31:0]       imm,
    output aluOpT             aluOp,
    output logic              aluWord,
    output logic              mulDiv,
    output logic              aluASrcPc,
    output srcBT              srcB,
    output branchT            branch,
    output logic              memRd,
    output logic              memWr,
    output logic [2:0]        memOp,
    output logic              regWr,
    output logic              isCsr,
    output logic              isEcall,
    output logic              isMret,
    output logic              isEbreak,
    output logic              illegal
);

    logic [31:0] instrQ;      // registered instruction
    logic        rs1Ready;
    logic        rs2Ready;

    decodeCtrlIf ctrlBus ();

    decodeStage stage (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .jmp        (jmp),
        .validIn    (validIn),
        .instrError (instrError),
        .csrError   (csrError),
        .instrIn    (instr),
        .pcIn       (pcIn),
        .rs1Ready   (rs1Ready),
        .rs2Ready   (rs2Ready),
        .ctrl       (ctrlBus),
        .instr      (instrQ),
        .pc         (pc),
        .issueValid (issueValid),
        .rsBlock    (rsBlock),
        .isEcall    (isEcall),
        .isMret     (isMret),
        .isEbreak   (isEbreak),
        .illegal    (illegal)
    );

    instrDecoder decoder (
        .instr (instrQ),
        .ctrl  (ctrlBus)
    );

    immGen immUnit (
        .instr (instrQ[31:7]),
        .ctrl  (ctrlBus),
        .imm   (imm)
    );

    regScoreboard scoreboard (
        .clk      (clk),
        .rstN     (rstN),
        .issue    (issueValid),
        .regWr    (ctrlBus.regWr),
        .rd       (instrQ[11:7]),
        .rs1      (instrQ[19:15]),
        .rs2      (instrQ[24:20]),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .rs1Ready (rs1Ready),
        .rs2Ready (rs2Ready)
    );

    assign rd = instrQ[11:7];
    assign rs1 = instrQ[19:15];
    assign rs2 = instrQ[24:20];

    assign aluOp = ctrlBus.aluOp;
    assign aluWord = ctrlBus.aluWord;
    assign mulDiv = ctrlBus.mulDiv;
    assign aluASrcPc = ctrlBus.aluASrcPc;
    assign srcB = ctrlBus.srcB;
    assign branch = ctrlBus.branch;
    assign memRd = ctrlBus.memRd;
    assign memWr = ctrlBus.memWr;
    assign memOp = ctrlBus.memOp;
    assign regWr = ctrlBus.regWr;
    assign isCsr = ctrlBus.isCsr;

endmodule

/* design/immGen.sv */
`timescale 1ns/1ps

module immGen import decodePkg::*; (
    input  logic [31:7]          instr,
    decodeCtrlIf.consumer        ctrl,
    output logic [31:0]          imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (ctrl.immFmt)
            fmtI: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            fmtS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            fmtB: begin
                // bit 0 always zero, bit 11 comes from instr[7]
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            fmtU: begin
                imm = {instr[31:12], 12'h000};
            end
            fmtJ: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;                     // fmtR
            end
        endcase
    end

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import decodePkg::*; (
    input  logic [31:0]          instr,
    decodeCtrlIf.producer        ctrl
);

    opcodeT      opc;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        err;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        opc = opcodeT'(instr[6:2]);
        ctrl.immFmt = fmtR;
        ctrl.aluOp = aluAdd;
        ctrl.aluWord = 1'b0;
        ctrl.mulDiv = 1'b0;
        ctrl.aluASrcPc = 1'b0;
        ctrl.srcB = srcRs2;
        ctrl.branch = brNone;
        ctrl.memRd = 1'b0;
        ctrl.memWr = 1'b0;
        ctrl.memOp = funct3;
        ctrl.regWr = 1'b1;
        ctrl.isCsr = 1'b0;
        err = 1'b0;
        case (opc)
            opLui: begin
                ctrl.immFmt = fmtU;
                ctrl.aluOp = aluPass;
                ctrl.srcB = srcImm;
            end
            opAuipc: begin
                ctrl.immFmt = fmtU;
                ctrl.aluASrcPc = 1'b1;
                ctrl.srcB = srcImm;
            end
            opJal: begin
                ctrl.immFmt = fmtJ;
                ctrl.aluASrcPc = 1'b1;    // link = pc + 4
                ctrl.srcB = srcFour;
                ctrl.branch = brJal;
            end
            opJalr: begin
                ctrl.immFmt = fmtI;
                ctrl.aluASrcPc = 1'b1;
                ctrl.srcB = srcFour;
                ctrl.branch = brJalr;
                err = (funct3 != 3'b000);
            end
            opBranch: begin
                ctrl.immFmt = fmtB;
                ctrl.regWr = 1'b0;
                ctrl.aluOp = funct3[1] ? aluSltu : aluSlt;    // bltu/bgeu compare unsigned
                case (funct3)
                    3'b000: ctrl.branch = brEq;
                    3'b001: ctrl.branch = brNe;
                    3'b100, 3'b110: ctrl.branch = brLt;
                    3'b101, 3'b111: ctrl.branch = brGe;
                    default: err = 1'b1;
                endcase
            end
            opLoad: begin
                ctrl.immFmt = fmtI;
                ctrl.srcB = srcImm;
                ctrl.memRd = 1'b1;
                err = (funct3 == 3'b111);
            end
            opStore: begin
                ctrl.immFmt = fmtS;
                ctrl.srcB = srcImm;
                ctrl.memWr = 1'b1;
                ctrl.regWr = 1'b0;
                err = funct3[2];              // sb..sd only
            end
            opOpImm: begin
                ctrl.immFmt = fmtI;
                ctrl.srcB = srcImm;
                ctrl.aluOp = aluOpT'({funct7[5] && funct3 == 3'b101, funct3});
                // six-bit shamt, so funct7[0] belongs to the amount
                if (funct3 == 3'b001) begin
                    err = (funct7[6:1] != 6'b000000);
                end else if (funct3 == 3'b101) begin
                    err = (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
                end
            end
            opOpImmW: begin
                ctrl.immFmt = fmtI;
                ctrl.srcB = srcImm;
                ctrl.aluWord = 1'b1;
                ctrl.aluOp = aluOpT'({funct7[5] && funct3 == 3'b101, funct3});
                case (funct3)
                    3'b000: err = 1'b0;
                    3'b001: err = (funct7 != 7'b0000000);
                    3'b101: err = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    default: err = 1'b1;
                endcase
            end
            opOp: begin
                ctrl.aluOp = aluOpT'({funct7[5], funct3});
                ctrl.mulDiv = (funct7 == 7'b0000001);
                case (funct7)
                    7'b0000000, 7'b0000001: err = 1'b0;
                    7'b0100000: err = (funct3 != 3'b000) && (funct3 != 3'b101);
                    default: err = 1'b1;
                endcase
            end
            opOpW: begin
                ctrl.aluWord = 1'b1;
                ctrl.aluOp = aluOpT'({funct7[5], funct3});
                ctrl.mulDiv = (funct7 == 7'b0000001);
                case (funct7)
                    7'b0000000: err = !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'b0100000: err = !(funct3 inside {3'b000, 3'b101});
                    7'b0000001: err = funct3 inside {3'b001, 3'b010, 3'b011};
                    default: err = 1'b1;
                endcase
            end
            opSystem: begin
                ctrl.immFmt = fmtI;          // rs1 or uimm field
                ctrl.aluOp = aluPass;
                ctrl.srcB = srcCsr;
                ctrl.isCsr = 1'b1;
                err = (funct3 == 3'b100);
            end
            default: begin
                ctrl.regWr = 1'b0;
                err = 1'b1;                   // unknown opcode
            end
        endcase
        ctrl.decErr = err || (instr[1:0] != 2'b11);
    end

endmodule

/* design/regScoreboard.sv */
`timescale 1ns/1ps

module regScoreboard import decodePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        issue,
    input  logic        regWr,
    input  logic [4:0]  rd,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        wbValid,
    input  logic [4:0]  wbRd,
    output logic        rs1Ready,
    output logic        rs2Ready
);

    logic [regCount-1:1] pending;     // x0 has no entry
    logic [regCount-1:1] setMask;
    logic [regCount-1:1] clrMask;
    logic [regCount-1:0] pendAll;

    always_comb begin
        for (int r = 1; r < regCount; r++) begin
            setMask[r] = issue && regWr && (rd == 5'(r));
            clrMask[r] = wbValid && (wbRd == 5'(r));
        end
    end

    // set wins over a same-cycle write-back
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clrMask) | setMask;
        end
    end

    assign pendAll = {pending, 1'b0};

    assign rs1Ready = !pendAll[rs1];
    assign rs2Ready = !pendAll[rs2];

endmodule

/* verilog.f */
design/decodePkg.sv
design/decodeCtrlIf.sv
design/instrDecoder.sv
design/immGen.sv
design/regScoreboard.sv
design/decodeStage.sv
design/decodeTop.sv
bench/decodeTb.sv
